// File: genbus_settings.svh
// Address map, memory sizes and mapper constants for the console system bus
`ifndef GENBUS_SETTINGS_SVH
`define GENBUS_SETTINGS_SVH

// --------------------
// Memory sizes

// Work RAM word address width, 32K words
`define WRAM_ADDR_BITS 15
// Cartridge SRAM, one byte per word address
`define SRAM_ADDR_BITS 16
// Z80 RAM, 8 KB
`define ZRAM_ADDR_BITS 13

// --------------------
// Main bus regions

// First 1 MB page above the cartridge ROM area
`define ROM_REGION_TOP 4'hA
// 200000-3FFFFF, compared on address bits 23:21
`define SRAM_REGION_PAGE 3'b001
// Z80 bus window seen from the 68K, bits 23:16
`define ZBUS_PAGE 8'hA0
// Z80 busreq and reset registers, bits 23:12
`define CTRL_PAGE 12'hA11
// A130F0-A130FF, bits 23:4
`define BANK_REG_PAGE 20'hA130F
// Z80 low addresses land on C000xx
`define Z80_LOW_PAGE 16'hC000

// --------------------
// Z80 side

// Z80 local space ends at 7EFF
`define ZLOCAL_TOP 7'h7F
// Window register write page 6000-60FF
`define ZBANK_SEL_PAGE 7'h60
`define ZBANK_WIDTH 9

// --------------------
// Mapper and open bus

// 2 MB in 16-bit words, romsz is a word count
`define SRAM_BANK_ROMSZ 23'h100000
`define ROM_BANK_BITS 5
`define OPEN_BUS_WORD 16'hFFFF

`endif

// File: genbus_pkg.sv
// Shared bus types and state encodings for the console system bus
`default_nettype none

package genbus_pkg;

	// --------------------
	// Data and address types

	typedef logic [15:0] word_t;
	typedef logic [7:0] byte_t;

	// 68K word address, no A0 on the bus
	typedef logic [23:1] m68k_addr_t;
	typedef logic [15:0] z80_addr_t;
	// Byte address inside the Z80 bus
	typedef logic [14:0] zbus_addr_t;

	// --------------------
	// Encodings

	typedef enum logic {
		SRC_M68K,
		SRC_Z80
	} bus_src_t;

	typedef enum logic [3:0] {
		MB_IDLE,
		MB_SELECT,
		MB_RAM_READ,
		MB_ROM_READ,
		MB_SRAM_READ,
		MB_ZBUS_PRE,
		MB_ZBUS_READ,
		MB_FINISH
	} mbus_state_t;

	typedef enum logic [1:0] {
		ZB_IDLE,
		ZB_READ,
		ZB_FINISH
	} zbus_state_t;

	// Cartridge mapper mode, set through A130Fx
	typedef enum logic [1:0] {
		BANK_NONE,
		BANK_SRAM,
		BANK_ROM
	} bank_mode_t;

endpackage

`default_nettype wire

// File: main_memories.sv
// Work RAM byte lanes and cartridge SRAM on the main bus
`timescale 1ns/10ps
`default_nettype none
`include "genbus_settings.svh"

module main_memories
	import genbus_pkg::*;
(
	input  wire             MCLK,
	input  wire m68k_addr_t mbus_a,
	input  wire word_t      mbus_do,
	input  wire             mbus_rnw,
	input  wire             mbus_uds_n,
	input  wire             mbus_lds_n,
	input  wire             wram_sel,
	input  wire             sram_sel,
	output word_t           wram_q,
	output byte_t           sram_q
);

	byte_t wram_hi [2**`WRAM_ADDR_BITS];
	byte_t wram_lo [2**`WRAM_ADDR_BITS];
	byte_t sram [2**`SRAM_ADDR_BITS];
	logic wram_we;
	logic sram_we;

	assign wram_we = wram_sel & ~mbus_rnw;
	// Cartridge SRAM sits on the odd byte
	assign sram_we = sram_sel & ~mbus_rnw & ~mbus_lds_n;

	// --------------------
	// 68K work RAM
	always_ff @(posedge MCLK) begin
		if (wram_we && !mbus_uds_n)
			wram_hi[mbus_a[`WRAM_ADDR_BITS:1]] <= mbus_do[15:8];
		if (wram_we && !mbus_lds_n)
			wram_lo[mbus_a[`WRAM_ADDR_BITS:1]] <= mbus_do[7:0];
		wram_q <= {wram_hi[mbus_a[`WRAM_ADDR_BITS:1]], wram_lo[mbus_a[`WRAM_ADDR_BITS:1]]};
	end

	// --------------------
	// 64 KB SRAM
	always_ff @(posedge MCLK) begin
		if (sram_we)
			sram[mbus_a[`SRAM_ADDR_BITS:1]] <= mbus_do[7:0];
		sram_q <= sram[mbus_a[`SRAM_ADDR_BITS:1]];
	end

endmodule

`default_nettype wire

// File: main_bus_arbiter.sv
// Main bus arbiter that sequences 68K and Z80 accesses and decodes the address map
`timescale 1ns/10ps
`default_nettype none
`include "genbus_settings.svh"

module main_bus_arbiter
	import genbus_pkg::*;
(
	input  wire                     MCLK,
	input  wire                     reset,
	input  wire m68k_addr_t         m68k_a,
	input  wire word_t              m68k_do,
	input  wire                     m68k_as_n,
	input  wire                     m68k_uds_n,
	input  wire                     m68k_lds_n,
	input  wire                     m68k_rnw,
	input  wire z80_addr_t          z80_a,
	input  wire byte_t              z80_do,
	input  wire                     z80_mreq_n,
	input  wire                     z80_rd_n,
	input  wire                     z80_wr_n,
	input  wire [`ZBANK_WIDTH-1:0]  zbank,
	input  wire m68k_addr_t         romsz,
	input  wire                     rom_ack,
	input  wire word_t              rom_data,
	input  wire word_t              wram_q,
	input  wire byte_t              sram_q,
	input  wire byte_t              mbus_zbus_d,
	input  wire                     mbus_zbus_dtack_n,
	input  wire                     z80_local,
	output word_t                   m68k_di,
	output logic                    m68k_dtack_n,
	output byte_t                   z80_mbus_d,
	output logic                    z80_mbus_dtack_n,
	output m68k_addr_t              rom_addr,
	output logic                    rom_req,
	output m68k_addr_t              mbus_a,
	output word_t                   mbus_do,
	output logic                    mbus_rnw,
	output logic                    mbus_uds_n,
	output logic                    mbus_lds_n,
	output logic                    wram_sel,
	output logic                    sram_sel,
	output logic                    zbus_sel,
	output logic                    z80_busreq_n,
	output logic                    z80_reset_n
);

	localparam word_t OPEN_BUS = `OPEN_BUS_WORD;

	mbus_state_t state;
	bus_src_t src;
	word_t data;
	bank_mode_t bank_mode;
	logic [`ROM_BANK_BITS-1:0] bank_reg [8];
	logic z80_io;
	logic ctrl_bit;

	assign z80_io = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);

	// Mapper splits the ROM into 512 KB pages
	assign rom_addr = (bank_mode == BANK_ROM) ?
		{bank_reg[mbus_a[21:19]], mbus_a[18:1]} : mbus_a;

	// Readback of A11100 and A11200, bit 8 only
	always_comb begin
		case (mbus_a[11:8])
		4'd1: ctrl_bit = z80_busreq_n;
		4'd2: ctrl_bit = z80_reset_n;
		default: ctrl_bit = OPEN_BUS[8];
		endcase
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= MB_IDLE;
			src <= SRC_M68K;
			m68k_dtack_n <= 1'b1;
			z80_mbus_dtack_n <= 1'b1;
			rom_req <= rom_ack;
			mbus_rnw <= 1'b1;
			mbus_uds_n <= 1'b1;
			mbus_lds_n <= 1'b1;
			wram_sel <= 1'b0;
			sram_sel <= 1'b0;
			zbus_sel <= 1'b0;
			z80_busreq_n <= 1'b1;
			z80_reset_n <= 1'b0;
			bank_mode <= BANK_NONE;
			for (int i = 0; i < 8; i++)
				bank_reg[i] <= i[`ROM_BANK_BITS-1:0];
		end else begin
			// Acknowledges drop once the master lets go
			if (m68k_as_n)
				m68k_dtack_n <= 1'b1;
			if (!z80_io)
				z80_mbus_dtack_n <= 1'b1;

			case (state)
			// --------------------
			// Arbitration, 68K first
			MB_IDLE: begin
				mbus_rnw <= 1'b1;
				mbus_uds_n <= 1'b1;
				mbus_lds_n <= 1'b1;
				data <= OPEN_BUS;
				if (!m68k_as_n && m68k_dtack_n) begin
					src <= SRC_M68K;
					mbus_a <= m68k_a;
					mbus_do <= m68k_do;
					mbus_rnw <= m68k_rnw;
					mbus_uds_n <= m68k_uds_n;
					mbus_lds_n <= m68k_lds_n;
					state <= MB_SELECT;
				end else if (z80_io && !z80_local && z80_mbus_dtack_n) begin
					src <= SRC_Z80;
					// Upper half goes through the window register
					mbus_a <= z80_a[15] ? {zbank, z80_a[14:1]} : {`Z80_LOW_PAGE, z80_a[7:1]};
					mbus_do <= {z80_do, z80_do};
					mbus_rnw <= z80_wr_n;
					mbus_uds_n <= z80_a[0];
					mbus_lds_n <= ~z80_a[0];
					state <= MB_SELECT;
				end
			end

			// --------------------
			// Address decode
			MB_SELECT: begin
				state <= MB_FINISH;
				if (mbus_a[23:20] < `ROM_REGION_TOP) begin
					if (bank_mode == BANK_SRAM && mbus_a[23:21] == `SRAM_REGION_PAGE) begin
						sram_sel <= 1'b1;
						state <= MB_SRAM_READ;
					end else if (mbus_a < romsz) begin
						rom_req <= ~rom_ack;
						state <= MB_ROM_READ;
					end else if (mbus_a[23:21] == `SRAM_REGION_PAGE && !(&mbus_a[20:19])) begin
						// 200000-37FFFF past the end of ROM
						sram_sel <= 1'b1;
						state <= MB_SRAM_READ;
					end else begin
						data <= '0;
					end
				end else if (&mbus_a[23:21]) begin
					wram_sel <= 1'b1;
					state <= MB_RAM_READ;
				end else if (mbus_a[23:16] == `ZBUS_PAGE) begin
					state <= MB_ZBUS_PRE;
				end else if (mbus_a[23:12] == `CTRL_PAGE && mbus_a[7:1] == 7'd0) begin
					data <= {OPEN_BUS[15:9], ctrl_bit, OPEN_BUS[7:0]};
					if (!mbus_rnw && !mbus_uds_n) begin
						if (mbus_a[11:8] == 4'd1)
							z80_busreq_n <= ~mbus_do[8];
						if (mbus_a[11:8] == 4'd2)
							z80_reset_n <= mbus_do[8];
					end
				end else if (mbus_a[23:4] == `BANK_REG_PAGE && !mbus_rnw) begin
					if (romsz > `SRAM_BANK_ROMSZ) begin
						// Large ROM, register 0 stays fixed
						if (mbus_a[3:1] != 3'd0) begin
							bank_reg[mbus_a[3:1]] <= mbus_do[`ROM_BANK_BITS-1:0];
							bank_mode <= BANK_ROM;
						end
					end else begin
						bank_mode <= mbus_do[0] ? BANK_SRAM : BANK_NONE;
					end
				end
			end

			// Waits for a data strobe so writes carry valid lanes
			MB_ZBUS_PRE: begin
				if (src == SRC_Z80 || m68k_as_n || !m68k_uds_n || !m68k_lds_n) begin
					zbus_sel <= 1'b1;
					state <= MB_ZBUS_READ;
				end
			end

			MB_ZBUS_READ: begin
				if (!mbus_zbus_dtack_n) begin
					zbus_sel <= 1'b0;
					data <= {mbus_zbus_d, mbus_zbus_d};
					state <= MB_FINISH;
				end
			end

			MB_RAM_READ: begin
				wram_sel <= 1'b0;
				data <= wram_q;
				state <= MB_FINISH;
			end

			MB_ROM_READ: begin
				if (rom_req == rom_ack) begin
					data <= rom_data;
					state <= MB_FINISH;
				end
			end

			MB_SRAM_READ: begin
				sram_sel <= 1'b0;
				data <= {sram_q, sram_q};
				state <= MB_FINISH;
			end

			// --------------------
			// Hand the result back
			MB_FINISH: begin
				if (src == SRC_Z80) begin
					z80_mbus_d <= z80_a[0] ? data[7:0] : data[15:8];
					z80_mbus_dtack_n <= 1'b0;
					state <= MB_IDLE;
				end else if (m68k_as_n) begin
					state <= MB_IDLE;
				end else begin
					m68k_di <= data;
					m68k_dtack_n <= 1'b0;
				end
			end

			default: state <= MB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: z80_bus_arbiter.sv
// Z80 bus arbiter serving the Z80 RAM and the window register to both masters
`timescale 1ns/10ps
`default_nettype none
`include "genbus_settings.svh"

module z80_bus_arbiter
	import genbus_pkg::*;
(
	input  wire                     MCLK,
	input  wire                     reset,
	input  wire                     zbus_sel,
	input  wire m68k_addr_t         mbus_a,
	input  wire word_t              mbus_do,
	input  wire                     mbus_rnw,
	input  wire                     mbus_uds_n,
	input  wire                     z80_busreq_n,
	input  wire                     z80_reset_n,
	input  wire z80_addr_t          z80_a,
	input  wire byte_t              z80_do,
	input  wire                     z80_mreq_n,
	input  wire                     z80_rd_n,
	input  wire                     z80_wr_n,
	output byte_t                   mbus_zbus_d,
	output logic                    mbus_zbus_dtack_n,
	output byte_t                   z80_zbus_d,
	output logic                    z80_zbus_dtack_n,
	output logic [`ZBANK_WIDTH-1:0] zbank,
	output logic                    z80_local
);

	zbus_state_t state;
	bus_src_t src;
	zbus_addr_t zbus_a;
	byte_t zbus_do;
	logic zbus_we;
	byte_t zram [2**`ZRAM_ADDR_BITS];
	byte_t zram_q;
	byte_t zbus_di;
	logic z80_io;
	logic z80_zbus_sel;
	logic zbus_free;
	logic zram_sel;
	logic bank_sel;

	// Z80 0000-7EFF stays on this bus
	assign z80_local = ~z80_a[15] && (z80_a[14:8] != `ZLOCAL_TOP);
	assign z80_io = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);
	assign z80_zbus_sel = z80_local & z80_io;

	// 68K owns the bus only while the Z80 is halted and out of reset
	assign zbus_free = ~z80_busreq_n & z80_reset_n;

	// RAM at 0000-1FFF, mirrored at 2000-3FFF
	assign zram_sel = ~zbus_a[14];
	assign bank_sel = (zbus_a[14:8] == `ZBANK_SEL_PAGE);
	assign zbus_di = zram_sel ? zram_q : 8'hFF;

	always_ff @(posedge MCLK) begin
		if (zbus_we && zram_sel)
			zram[zbus_a[`ZRAM_ADDR_BITS-1:0]] <= zbus_do;
		zram_q <= zram[zbus_a[`ZRAM_ADDR_BITS-1:0]];
	end

	// --------------------
	// Access sequencer
	always_ff @(posedge MCLK) begin
		if (reset) begin
			state <= ZB_IDLE;
			src <= SRC_M68K;
			zbus_we <= 1'b0;
			mbus_zbus_dtack_n <= 1'b1;
			z80_zbus_dtack_n <= 1'b1;
		end else begin
			zbus_we <= 1'b0;
			if (!zbus_sel)
				mbus_zbus_dtack_n <= 1'b1;
			if (!z80_zbus_sel)
				z80_zbus_dtack_n <= 1'b1;

			case (state)
			ZB_IDLE: begin
				if (zbus_sel && mbus_zbus_dtack_n) begin
					zbus_a <= {mbus_a[14:1], mbus_uds_n};
					zbus_do <= (!mbus_uds_n) ? mbus_do[15:8] : mbus_do[7:0];
					zbus_we <= ~mbus_rnw & zbus_free;
					src <= SRC_M68K;
					state <= ZB_READ;
				end else if (z80_zbus_sel && z80_zbus_dtack_n) begin
					zbus_a <= z80_a[14:0];
					zbus_do <= z80_do;
					zbus_we <= ~z80_wr_n;
					src <= SRC_Z80;
					state <= ZB_READ;
				end
			end

			// RAM read and write happen here
			ZB_READ: state <= ZB_FINISH;

			ZB_FINISH: begin
				if (src == SRC_M68K) begin
					mbus_zbus_d <= zbus_free ? zbus_di : 8'hFF;
					mbus_zbus_dtack_n <= 1'b0;
				end else begin
					z80_zbus_d <= zbus_di;
					z80_zbus_dtack_n <= 1'b0;
				end
				state <= ZB_IDLE;
			end

			default: state <= ZB_IDLE;
			endcase
		end
	end

	// Window register loads serially, one bit per write
	always_ff @(posedge MCLK) begin
		if (reset)
			zbank <= '0;
		else if (bank_sel && zbus_we)
			zbank <= {zbus_do[0], zbank[`ZBANK_WIDTH-1:1]};
	end

endmodule

`default_nettype wire

// File: genbus_top.sv
// Console system bus top level joining both arbiters and the main memories
`timescale 1ns/10ps
`default_nettype none
`include "genbus_settings.svh"

module genbus_top
	import genbus_pkg::*;
(
	input  wire             MCLK,
	input  wire             reset,

	// 68K bus
	input  wire m68k_addr_t m68k_a,
	input  wire word_t      m68k_do,
	input  wire             m68k_as_n,
	input  wire             m68k_uds_n,
	input  wire             m68k_lds_n,
	input  wire             m68k_rnw,
	output word_t           m68k_di,
	output logic            m68k_dtack_n,

	// Z80 bus
	input  wire z80_addr_t  z80_a,
	input  wire byte_t      z80_do,
	input  wire             z80_mreq_n,
	input  wire             z80_rd_n,
	input  wire             z80_wr_n,
	output byte_t           z80_di,
	output logic            z80_wait_n,
	output logic            z80_busreq_n,
	output logic            z80_reset_n,

	// Cartridge ROM port
	input  wire m68k_addr_t romsz,
	output m68k_addr_t      rom_addr,
	output logic            rom_req,
	input  wire             rom_ack,
	input  wire word_t      rom_data
);

	// --------------------
	// Main bus
	m68k_addr_t mbus_a;
	word_t mbus_do;
	logic mbus_rnw;
	logic mbus_uds_n;
	logic mbus_lds_n;
	logic wram_sel;
	logic sram_sel;
	logic zbus_sel;
	word_t wram_q;
	byte_t sram_q;

	// Z80 bus results
	byte_t mbus_zbus_d;
	logic mbus_zbus_dtack_n;
	byte_t z80_zbus_d;
	logic z80_zbus_dtack_n;
	byte_t z80_mbus_d;
	logic z80_mbus_dtack_n;
	logic [`ZBANK_WIDTH-1:0] zbank;
	logic z80_local;
	logic z80_io;

	main_bus_arbiter u_main_bus_arbiter (
		.MCLK(MCLK),
		.reset(reset),
		.m68k_a(m68k_a),
		.m68k_do(m68k_do),
		.m68k_as_n(m68k_as_n),
		.m68k_uds_n(m68k_uds_n),
		.m68k_lds_n(m68k_lds_n),
		.m68k_rnw(m68k_rnw),
		.z80_a(z80_a),
		.z80_do(z80_do),
		.z80_mreq_n(z80_mreq_n),
		.z80_rd_n(z80_rd_n),
		.z80_wr_n(z80_wr_n),
		.zbank(zbank),
		.romsz(romsz),
		.rom_ack(rom_ack),
		.rom_data(rom_data),
		.wram_q(wram_q),
		.sram_q(sram_q),
		.mbus_zbus_d(mbus_zbus_d),
		.mbus_zbus_dtack_n(mbus_zbus_dtack_n),
		.z80_local(z80_local),
		.m68k_di(m68k_di),
		.m68k_dtack_n(m68k_dtack_n),
		.z80_mbus_d(z80_mbus_d),
		.z80_mbus_dtack_n(z80_mbus_dtack_n),
		.rom_addr(rom_addr),
		.rom_req(rom_req),
		.mbus_a(mbus_a),
		.mbus_do(mbus_do),
		.mbus_rnw(mbus_rnw),
		.mbus_uds_n(mbus_uds_n),
		.mbus_lds_n(mbus_lds_n),
		.wram_sel(wram_sel),
		.sram_sel(sram_sel),
		.zbus_sel(zbus_sel),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n)
	);

	z80_bus_arbiter u_z80_bus_arbiter (
		.MCLK(MCLK),
		.reset(reset),
		.zbus_sel(zbus_sel),
		.mbus_a(mbus_a),
		.mbus_do(mbus_do),
		.mbus_rnw(mbus_rnw),
		.mbus_uds_n(mbus_uds_n),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n),
		.z80_a(z80_a),
		.z80_do(z80_do),
		.z80_mreq_n(z80_mreq_n),
		.z80_rd_n(z80_rd_n),
		.z80_wr_n(z80_wr_n),
		.mbus_zbus_d(mbus_zbus_d),
		.mbus_zbus_dtack_n(mbus_zbus_dtack_n),
		.z80_zbus_d(z80_zbus_d),
		.z80_zbus_dtack_n(z80_zbus_dtack_n),
		.zbank(zbank),
		.z80_local(z80_local)
	);

	main_memories u_main_memories (
		.MCLK(MCLK),
		.mbus_a(mbus_a),
		.mbus_do(mbus_do),
		.mbus_rnw(mbus_rnw),
		.mbus_uds_n(mbus_uds_n),
		.mbus_lds_n(mbus_lds_n),
		.wram_sel(wram_sel),
		.sram_sel(sram_sel),
		.wram_q(wram_q),
		.sram_q(sram_q)
	);

	// --------------------
	// Z80 wait and read data
	assign z80_io = ~z80_mreq_n & (~z80_rd_n | ~z80_wr_n);

	// Wait released by either acknowledge, idle bus never waits
	assign z80_wait_n = ~z80_mbus_dtack_n | ~z80_zbus_dtack_n | ~z80_io;
	assign z80_di = (~z80_zbus_dtack_n) ? z80_zbus_d : z80_mbus_d;

endmodule

`default_nettype wire

// File: tb_genbus.sv
// Directed testbench for the console system bus with a cartridge ROM model
`timescale 1ns/10ps
`default_nettype none
`include "genbus_settings.svh"

module tb_genbus
	import genbus_pkg::*;
;

	localparam int CLK_NS = 100;
	localparam int RESET_CYCLES = 3;
	localparam int BUS_LIMIT = 40;
	localparam logic [15:0] LFSR_SEED = 16'd54260;
	localparam word_t OPEN_BUS = `OPEN_BUS_WORD;

	// ROM sizes as word counts
	localparam m68k_addr_t ROMSZ_1MB = 23'h080000;
	localparam m68k_addr_t ROMSZ_2MB = 23'h100000;
	localparam m68k_addr_t ROMSZ_4MB = 23'h200000;

	// Test lengths, in bus accesses
	localparam int WRAM_ITER = 6;
	localparam int ROM_ITER = 6;
	localparam int Z80_ITER = 6;
	localparam int TOTAL_ACCESSES = 3 * WRAM_ITER + ROM_ITER + 3 + 6 + 8 + 2 * Z80_ITER + 10 + 2;
	localparam int ACCESS_CYCLES = 16;
	localparam int WATCHDOG_NS =
		(TOTAL_ACCESSES * ACCESS_CYCLES + 6 * (RESET_CYCLES + 1)) * CLK_NS + 200000;

	logic MCLK;
	logic reset;
	m68k_addr_t m68k_a;
	word_t m68k_do;
	logic m68k_as_n;
	logic m68k_uds_n;
	logic m68k_lds_n;
	logic m68k_rnw;
	word_t m68k_di;
	logic m68k_dtack_n;
	z80_addr_t z80_a;
	byte_t z80_do;
	logic z80_mreq_n;
	logic z80_rd_n;
	logic z80_wr_n;
	byte_t z80_di;
	logic z80_wait_n;
	logic z80_busreq_n;
	logic z80_reset_n;
	m68k_addr_t romsz;
	m68k_addr_t rom_addr;
	logic rom_req;
	logic rom_ack;
	word_t rom_data;

	m68k_addr_t rom_last_addr;
	int rom_wait;
	logic [15:0] lfsr_state;
	int checks;
	int errors;

	genbus_top uut (
		.MCLK(MCLK),
		.reset(reset),
		.m68k_a(m68k_a),
		.m68k_do(m68k_do),
		.m68k_as_n(m68k_as_n),
		.m68k_uds_n(m68k_uds_n),
		.m68k_lds_n(m68k_lds_n),
		.m68k_rnw(m68k_rnw),
		.m68k_di(m68k_di),
		.m68k_dtack_n(m68k_dtack_n),
		.z80_a(z80_a),
		.z80_do(z80_do),
		.z80_mreq_n(z80_mreq_n),
		.z80_rd_n(z80_rd_n),
		.z80_wr_n(z80_wr_n),
		.z80_di(z80_di),
		.z80_wait_n(z80_wait_n),
		.z80_busreq_n(z80_busreq_n),
		.z80_reset_n(z80_reset_n),
		.romsz(romsz),
		.rom_addr(rom_addr),
		.rom_req(rom_req),
		.rom_ack(rom_ack),
		.rom_data(rom_data)
	);

	initial begin
		MCLK = 1'b0;
		forever #(CLK_NS / 2) MCLK = ~MCLK;
	end

	// --------------------
	// Helpers

	// Inputs change 10 ns after the rising edge
	task automatic next_cycle();
		@(posedge MCLK);
		#10;
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input m68k_addr_t got, input m68k_addr_t exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (RESET_CYCLES) next_cycle();
		reset = 1'b0;
	endtask

	// --------------------
	// Bus masters

	task automatic m68k_cycle(input logic [23:0] addr, input logic rnw, input logic uds_n,
		input logic lds_n, input word_t wdata, output word_t rdata);
		int cycles;
		m68k_a = addr[23:1];
		m68k_rnw = rnw;
		m68k_uds_n = uds_n;
		m68k_lds_n = lds_n;
		m68k_do = wdata;
		m68k_as_n = 1'b0;
		next_cycle();
		cycles = 1;
		while (m68k_dtack_n && cycles < BUS_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (m68k_dtack_n) begin
			$display("68K access at address %h got no DTACK in %0d cycles", addr, BUS_LIMIT);
			errors++;
		end
		rdata = m68k_di;
		m68k_as_n = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw = 1'b1;
		next_cycle();
	endtask

	task automatic m68k_read(input logic [23:0] addr, input logic uds_n, input logic lds_n,
		output word_t rdata);
		m68k_cycle(addr, 1'b1, uds_n, lds_n, 16'h0000, rdata);
	endtask

	task automatic m68k_write(input logic [23:0] addr, input logic uds_n, input logic lds_n,
		input word_t wdata);
		word_t unused;
		m68k_cycle(addr, 1'b0, uds_n, lds_n, wdata, unused);
	endtask

	task automatic z80_cycle(input z80_addr_t addr, input logic wr, input byte_t wdata,
		output byte_t rdata);
		int cycles;
		z80_a = addr;
		z80_do = wdata;
		z80_mreq_n = 1'b0;
		z80_rd_n = wr;
		z80_wr_n = ~wr;
		next_cycle();
		cycles = 1;
		while (!z80_wait_n && cycles < BUS_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (!z80_wait_n) begin
			$display("Z80 access at address %h still waiting after %0d cycles", addr, BUS_LIMIT);
			errors++;
		end
		rdata = z80_di;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		// Acknowledge clears on this edge
		next_cycle();
	endtask

	task automatic z80_read(input z80_addr_t addr, output byte_t rdata);
		z80_cycle(addr, 1'b0, 8'h00, rdata);
	endtask

	task automatic z80_write(input z80_addr_t addr, input byte_t wdata);
		byte_t unused;
		z80_cycle(addr, 1'b1, wdata, unused);
	endtask

	// Cartridge ROM, answers each toggle after 2 to 4 cycles
	initial begin
		rom_ack = 1'b0;
		rom_data = '0;
		rom_last_addr = '0;
		rom_wait = 2;
		forever begin
			next_cycle();
			if (rom_req !== rom_ack) begin
				repeat (rom_wait) next_cycle();
				rom_last_addr = rom_addr;
				rom_data = rom_addr[16:1] ^ 16'hA5A5;
				rom_ack = rom_req;
				rom_wait = (rom_wait == 4) ? 2 : rom_wait + 1;
			end
		end
	end

	// --------------------
	// Directed tests

	task automatic work_ram_round_trip();
		logic [31:0] rnd;
		logic [23:0] addr;
		word_t wdata;
		word_t rdata;
		word_t expected;
		byte_t bdata;
		apply_reset();
		romsz = ROMSZ_4MB;
		for (int i = 0; i < WRAM_ITER; i++) begin
			rnd = random_bits(16);
			addr = {8'hE0, rnd[15:1], 1'b0};
			rnd = random_bits(16);
			wdata = rnd[15:0];
			rnd = random_bits(9);
			bdata = rnd[7:0];
			m68k_write(addr, 1'b0, 1'b0, wdata);
			if (rnd[8]) begin
				m68k_write(addr, 1'b0, 1'b1, {bdata, 8'h00});
				expected = {bdata, wdata[7:0]};
			end else begin
				m68k_write(addr, 1'b1, 1'b0, {8'h00, bdata});
				expected = {wdata[15:8], bdata};
			end
			m68k_read(addr, 1'b0, 1'b0, rdata);
			check_word("m68k_di", rdata, expected);
		end
	endtask

	task automatic rom_banking();
		logic [31:0] rnd;
		logic [23:0] addr;
		logic [4:0] bank;
		word_t rdata;
		apply_reset();
		romsz = ROMSZ_4MB;
		for (int i = 0; i < ROM_ITER; i++) begin
			rnd = random_bits(21);
			addr = {2'b00, rnd[20:0], 1'b0};
			m68k_read(addr, 1'b0, 1'b0, rdata);
			check_word("m68k_di", rdata, addr[16:1] ^ 16'hA5A5);
		end
		// Register 1 covers 080000-0FFFFF, banks 16-31 differ from its reset value
		rnd = random_bits(4);
		bank = {1'b1, rnd[3:0]};
		m68k_write(24'hA130F3, 1'b1, 1'b0, {11'h000, bank});
		rnd = random_bits(18);
		addr = {5'b00001, rnd[17:0], 1'b0};
		m68k_read(addr, 1'b0, 1'b0, rdata);
		check_addr("rom_addr", rom_last_addr, {bank, addr[18:1]});
		check_word("m68k_di", rdata, addr[16:1] ^ 16'hA5A5);
		// Past the end of ROM
		rnd = random_bits(21);
		addr = {2'b01, rnd[20:0], 1'b0};
		m68k_read(addr, 1'b0, 1'b0, rdata);
		check_word("m68k_di", rdata, 16'h0000);
	endtask

	task automatic sram_banking();
		logic [31:0] rnd;
		byte_t bdata;
		word_t rdata;
		apply_reset();
		romsz = ROMSZ_1MB;
		rnd = random_bits(8);
		bdata = rnd[7:0];
		m68k_write(24'h200001, 1'b1, 1'b0, {8'h00, bdata});
		m68k_read(24'h200000, 1'b0, 1'b0, rdata);
		check_word("m68k_di", rdata, {bdata, bdata});
		romsz = ROMSZ_2MB;
		m68k_write(24'hA130F1, 1'b1, 1'b0, 16'h0001);
		m68k_read(24'h200000, 1'b0, 1'b0, rdata);
		check_word("m68k_di", rdata, {bdata, bdata});
		// 380000-3FFFFF only reaches SRAM in bank mode
		rnd = random_bits(8);
		bdata = rnd[7:0];
		m68k_write(24'h3E0001, 1'b1, 1'b0, {8'h00, bdata});
		m68k_read(24'h3E0000, 1'b0, 1'b0, rdata);
		check_word("m68k_di", rdata, {bdata, bdata});
	endtask

	task automatic z80_bus_grant();
		logic [31:0] rnd;
		byte_t bdata;
		word_t rdata;
		apply_reset();
		romsz = ROMSZ_4MB;
		check_bit("m68k_dtack_n", m68k_dtack_n, 1'b1);
		check_bit("z80_wait_n", z80_wait_n, 1'b1);
		check_bit("rom_req", rom_req, rom_ack);
		check_bit("z80_busreq_n", z80_busreq_n, 1'b1);
		check_bit("z80_reset_n", z80_reset_n, 1'b0);
		m68k_read(24'hA11100, 1'b0, 1'b0, rdata);
		check_word("m68k_di", rdata, OPEN_BUS);
		m68k_write(24'hA11100, 1'b0, 1'b0, 16'h0100);
		m68k_write(24'hA11200, 1'b0, 1'b0, 16'h0100);
		check_bit("z80_busreq_n", z80_busreq_n, 1'b0);
		check_bit("z80_reset_n", z80_reset_n, 1'b1);
		m68k_read(24'hA11100, 1'b0, 1'b0, rdata);
		check_word("m68k_di", rdata, OPEN_BUS & 16'hFEFF);
		rnd = random_bits(8);
		bdata = rnd[7:0];
		m68k_write(24'hA00010, 1'b0, 1'b1, {bdata, 8'h00});
		m68k_read(24'hA00010, 1'b0, 1'b1, rdata);
		check_byte("m68k_di[15:8]", rdata[15:8], bdata);
		// Release the bus, Z80 side takes it back
		m68k_write(24'hA11100, 1'b0, 1'b0, 16'h0000);
		m68k_read(24'hA00010, 1'b0, 1'b1, rdata);
		check_byte("m68k_di[15:8]", rdata[15:8], 8'hFF);
	endtask

	task automatic z80_local_and_window();
		logic [31:0] rnd;
		z80_addr_t zaddr;
		byte_t bdata;
		byte_t rbyte;
		logic [8:0] bank;
		logic [14:0] off;
		word_t rom_word;
		apply_reset();
		romsz = ROMSZ_4MB;
		for (int i = 0; i < Z80_ITER; i++) begin
			rnd = random_bits(21);
			zaddr = {3'b000, rnd[12:0]};
			bdata = rnd[20:13];
			z80_write(zaddr, bdata);
			z80_read(zaddr, rbyte);
			check_byte("z80_di", rbyte, bdata);
		end
		// Window below 4 MB so it lands in ROM, LSB shifted in first
		rnd = random_bits(7);
		bank = {2'b00, rnd[6:0]};
		for (int i = 0; i < 9; i++)
			z80_write(16'h6000, {7'h00, bank[i]});
		rnd = random_bits(15);
		off = rnd[14:0];
		z80_read({1'b1, off}, rbyte);
		rom_word = {bank[1:0], off[14:1]} ^ 16'hA5A5;
		check_addr("rom_addr", rom_last_addr, {bank, off[14:1]});
		check_byte("z80_di", rbyte, off[0] ? rom_word[7:0] : rom_word[15:8]);
	endtask

	task automatic open_bus_reads();
		word_t rdata;
		apply_reset();
		romsz = ROMSZ_4MB;
		m68k_read(24'hA10000, 1'b0, 1'b0, rdata);
		check_word("m68k_di", rdata, OPEN_BUS);
		m68k_read(24'hC00000, 1'b0, 1'b0, rdata);
		check_word("m68k_di", rdata, OPEN_BUS);
	endtask

	// --------------------
	// Sequence and watchdog

	initial begin
		reset = 1'b1;
		m68k_a = '0;
		m68k_do = '0;
		m68k_as_n = 1'b1;
		m68k_uds_n = 1'b1;
		m68k_lds_n = 1'b1;
		m68k_rnw = 1'b1;
		z80_a = '0;
		z80_do = '0;
		z80_mreq_n = 1'b1;
		z80_rd_n = 1'b1;
		z80_wr_n = 1'b1;
		romsz = ROMSZ_4MB;
		lfsr_state = LFSR_SEED;
		checks = 0;
		errors = 0;

		work_ram_round_trip();
		rom_banking();
		sram_banking();
		z80_bus_grant();
		z80_local_and_window();
		open_bus_reads();

		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
genbus_pkg.sv
main_memories.sv
main_bus_arbiter.sv
z80_bus_arbiter.sv
genbus_top.sv
tb_genbus.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the system bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module tb_genbus -f filelist.f

./obj_dir/Vtb_genbus | tee sim.log

if grep -q "^ALL CHECKS PASSED$" sim.log; then
	echo "Simulation result: pass"
else
	echo "Simulation result: fail"
	exit 1
fi
